// File: hdl/gb_bus_pkg.sv
package gb_bus_pkg;

	localparam int ADR_W      = 16;
	localparam int DATA_W     = 8;
	localparam int VRAM_ADR_W = 13;
	localparam int OAM_ADR_W  = 8;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [ADR_W-1:0] EXT_ROM_END = 16'h7fff;
	localparam logic [ADR_W-1:0] VRAM_BASE   = 16'h8000;
	localparam logic [ADR_W-1:0] VRAM_END    = 16'h9fff;
	localparam logic [ADR_W-1:0] XRAM_BASE   = 16'ha000;
	localparam logic [ADR_W-1:0] WRAM_BASE   = 16'hc000;
	localparam logic [ADR_W-1:0] WRAM_END    = 16'hdfff;
	localparam logic [ADR_W-1:0] OAM_BASE    = 16'hfe00;
	localparam logic [ADR_W-1:0] OAM_END     = 16'hfe9f;
	localparam logic [ADR_W-1:0] IO_BASE     = 16'hff00;
	localparam logic [ADR_W-1:0] DMA_REG_ADR = 16'hff46;

	localparam int OAM_BYTES = 160;
	// Pulled-up data lines
	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hff;

	typedef struct packed {
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} cpu_req_t;

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic             rd;
		logic             needs_vram;
		logic             needs_oam;
	} ppu_req_t;

	typedef struct packed {
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
		logic              cs_rom;
		logic              cs_xram;
		logic              cs_wram;
	} ext_bus_t;

	typedef struct packed {
		logic rom;
		logic xram;
		logic wram;
		logic vram;
		logic oam;
		logic io;
	} region_sel_t;

	typedef union packed {
		logic [ADR_W-1:0] raw;
		struct packed {
			logic [7:0] page;
			logic [7:0] offset;
		} paged;
	} bus_adr_u;

endpackage

// File: hdl/gb_reset_pkg.sv
package gb_reset_pkg;

	typedef enum logic [1:0] {
		INIT    = 2'd0,
		ASSERT  = 2'd1,
		RELEASE = 2'd2,
		DONE    = 2'd3
	} reset_state_t;

	// Cycles spent in each timed state
	localparam int TICK_W      = 4;
	localparam int STATE_TICKS = 16;

endpackage

// File: hdl/reset_tick_timer.sv
module reset_tick_timer (
	input  logic gbclk,
	input  logic rst_n,
	input  logic clear,
	output logic tick_done
);
	import gb_reset_pkg::*;

	logic [TICK_W-1:0] ticks;

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			ticks <= '0;
		end else if (clear) begin
			ticks <= '0;
		end else begin
			// Free running outside the timed states
			ticks <= ticks + 1'b1;
		end
	end

	// Last cycle of the state
	assign tick_done = ticks == TICK_W'(STATE_TICKS - 1);

endmodule

// File: hdl/reset_sequencer.sv
module reset_sequencer (
	input  logic gbclk,
	input  logic rst_n,
	input  logic gb_on,
	input  logic tick_done,
	output logic tick_clear,
	output logic reset_done,
	output logic gb_reset
);
	import gb_reset_pkg::*;

	reset_state_t state;
	reset_state_t state_nxt;
	logic         gb_on_q;
	logic         restart;

	// Power switch flips restart at ASSERT, INIT runs only once
	assign restart = (state != INIT) && (gb_on != gb_on_q);

	always_comb begin
		state_nxt = state;
		case (state)
			INIT:
				if (tick_done)
					state_nxt = ASSERT;
			ASSERT:
				if (tick_done)
					state_nxt = RELEASE;
			RELEASE:
				if (tick_done)
					state_nxt = DONE;
			default:
				state_nxt = DONE;
		endcase
		if (restart)
			state_nxt = ASSERT;
	end

	// Timer starts over on entry to every state
	assign tick_clear = restart || (state_nxt != state);

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= INIT;
			gb_on_q <= 1'b0;
		end else begin
			state   <= state_nxt;
			gb_on_q <= gb_on;
		end
	end

	assign reset_done = state == DONE;
	assign gb_reset   = !reset_done || !gb_on;

endmodule

// File: hdl/gb_memmap.sv
module gb_memmap (
	input  gb_bus_pkg::bus_adr_u    adr,
	output gb_bus_pkg::region_sel_t sel,
	output logic                    dma_reg
);
	import gb_bus_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Region compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		sel.rom  = adr.raw <= EXT_ROM_END;
		sel.vram = (adr.raw >= VRAM_BASE) && (adr.raw <= VRAM_END);
		sel.xram = (adr.raw >= XRAM_BASE) && (adr.raw < WRAM_BASE);
		sel.wram = (adr.raw >= WRAM_BASE) && (adr.raw <= WRAM_END);
		// Echo RAM and the gap above OAM stay unmapped
		sel.oam  = (adr.raw >= OAM_BASE) && (adr.raw <= OAM_END);
		sel.io   = adr.paged.page == IO_BASE[15:8];
	end

	// I/O register number is the low byte
	assign dma_reg = sel.io && (adr.paged.offset == DMA_REG_ADR[7:0]);

endmodule

// File: hdl/oam_dma.sv
module oam_dma (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  logic                 bus_reset,
	input  logic                 start,
	input  logic [7:0]           page,
	output gb_bus_pkg::bus_adr_u src_adr,
	output logic                 src_rd,
	output logic [7:0]           oam_adr,
	output logic                 oam_wr,
	output logic                 active
);
	import gb_bus_pkg::*;

	logic                 issuing;
	logic [OAM_ADR_W-1:0] idx;
	logic [7:0]           page_q;
	logic                 wr_q;
	logic [OAM_ADR_W-1:0] wr_idx;

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			issuing <= 1'b0;
			idx     <= '0;
			page_q  <= '0;
			wr_q    <= 1'b0;
		end else if (bus_reset) begin
			// Console reset aborts a running copy
			issuing <= 1'b0;
			wr_q    <= 1'b0;
		end else begin
			wr_q <= issuing;
			if (start && !active) begin
				issuing <= 1'b1;
				idx     <= '0;
				page_q  <= page;
			end else if (issuing) begin
				if (idx == OAM_ADR_W'(OAM_BYTES - 1))
					issuing <= 1'b0;
				idx <= idx + 1'b1;
			end
		end
	end

	// Write stage trails the read by one cycle
	always_ff @(posedge gbclk) begin
		wr_idx <= idx;
	end

	always_comb begin
		src_adr.paged.page   = page_q;
		src_adr.paged.offset = idx;
	end

	assign src_rd  = issuing;
	assign oam_adr = wr_idx;
	assign oam_wr  = wr_q;
	assign active  = issuing || wr_q;

endmodule

// File: hdl/video_mem_arbiter.sv
module video_mem_arbiter (
	input  logic                    gbclk,
	input  logic                    rst_n,
	input  logic                    bus_reset,
	input  gb_bus_pkg::cpu_req_t    cpu,
	input  gb_bus_pkg::region_sel_t cpu_sel,
	input  gb_bus_pkg::ppu_req_t    ppu,
	input  gb_bus_pkg::region_sel_t dma_sel,
	input  gb_bus_pkg::bus_adr_u    dma_src_adr,
	input  logic                    dma_rd,
	input  logic                    dma_oam_wr,
	input  logic                    dma_active,
	input  logic [7:0]              dma_oam_adr,
	input  logic [7:0]              ext_rdata,
	output gb_bus_pkg::ext_bus_t    ext,
	output logic [7:0]              cpu_rdata,
	output logic [7:0]              ppu_rdata
);
	import gb_bus_pkg::*;

	logic [DATA_W-1:0]     vram_mem [2**VRAM_ADR_W];
	logic [DATA_W-1:0]     oam_mem [2**OAM_ADR_W];
	logic [DATA_W-1:0]     vram_q;
	logic [DATA_W-1:0]     oam_q;
	logic [VRAM_ADR_W-1:0] vram_adr;
	logic                  vram_rd;
	logic                  vram_wr;
	logic [OAM_ADR_W-1:0]  oam_adr;
	logic                  oam_rd;
	logic                  oam_wr;
	logic [DATA_W-1:0]     oam_din;
	logic [DATA_W-1:0]     dma_rdata;
	region_sel_t           ext_sel;
	logic                  cpu_rd;
	logic                  cpu_wr;
	logic                  dma_rd_g;
	logic                  cpu_ext;
	logic                  dma_vram;
	logic                  dma_ext;
	logic                  ppu_vram_rd;
	logic                  ppu_oam_rd;
	logic                  ppu_in_vram;
	// Read grants of the previous cycle
	logic cpu_vram_q, cpu_oam_q, cpu_ext_q, cpu_dreg_q;
	logic ppu_vram_q, ppu_oam_q;
	logic dma_vram_q, dma_ext_q;

	// No master gets through while the console is in reset
	assign cpu_rd   = cpu.rd && !bus_reset;
	assign cpu_wr   = cpu.wr && !bus_reset;
	assign dma_rd_g = dma_rd && !bus_reset;

	assign cpu_ext  = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_vram = dma_active && dma_sel.vram;
	assign dma_ext  = dma_active && (dma_sel.rom || dma_sel.xram || dma_sel.wram);

	assign ppu_in_vram = (ppu.adr >= VRAM_BASE) && (ppu.adr <= VRAM_END);
	assign ppu_vram_rd = ppu.rd && ppu.needs_vram && ppu_in_vram && !bus_reset;
	assign ppu_oam_rd  = ppu.rd && ppu.needs_oam && !ppu_in_vram && !bus_reset;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Port muxes, PPU then DMA then CPU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		vram_adr = cpu.adr[VRAM_ADR_W-1:0];
		vram_rd  = 1'b0;
		vram_wr  = 1'b0;
		if (ppu.needs_vram) begin
			vram_adr = ppu.adr[VRAM_ADR_W-1:0];
			vram_rd  = ppu_vram_rd;
		end else if (dma_vram) begin
			vram_adr = dma_src_adr.raw[VRAM_ADR_W-1:0];
			vram_rd  = dma_rd_g;
		end else if (cpu_sel.vram) begin
			vram_rd = cpu_rd;
			vram_wr = cpu_wr;
		end
	end

	always_comb begin
		oam_adr = cpu.adr[OAM_ADR_W-1:0];
		oam_din = cpu.wdata;
		oam_rd  = 1'b0;
		oam_wr  = 1'b0;
		if (ppu.needs_oam) begin
			oam_adr = ppu.adr[OAM_ADR_W-1:0];
			oam_rd  = ppu_oam_rd;
		end else if (dma_active) begin
			oam_adr = dma_oam_adr;
			oam_din = dma_rdata;
			oam_wr  = dma_oam_wr;
		end else if (cpu_sel.oam) begin
			oam_rd = cpu_rd;
			oam_wr = cpu_wr;
		end
	end

	always_ff @(posedge gbclk) begin
		if (vram_wr)
			vram_mem[vram_adr] <= cpu.wdata;
		if (vram_rd)
			vram_q <= vram_mem[vram_adr];
		if (oam_wr)
			oam_mem[oam_adr] <= oam_din;
		if (oam_rd)
			oam_q <= oam_mem[oam_adr];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// External bus, DMA ahead of CPU
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		ext.wdata = cpu.wdata;
		if (dma_ext) begin
			ext_sel = dma_sel;
			ext.adr = dma_src_adr.raw;
			ext.rd  = dma_rd_g;
			ext.wr  = 1'b0;
		end else begin
			ext_sel = cpu_sel;
			ext.adr = cpu.adr;
			ext.rd  = cpu_rd && cpu_ext;
			ext.wr  = cpu_wr && cpu_ext;
		end
		ext.cs_rom  = ext_sel.rom && (ext.rd || ext.wr);
		ext.cs_xram = ext_sel.xram && (ext.rd || ext.wr);
		ext.cs_wram = ext_sel.wram && (ext.rd || ext.wr);
	end

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			cpu_vram_q <= 1'b0;
			cpu_oam_q  <= 1'b0;
			cpu_ext_q  <= 1'b0;
			cpu_dreg_q <= 1'b0;
			ppu_vram_q <= 1'b0;
			ppu_oam_q  <= 1'b0;
			dma_vram_q <= 1'b0;
			dma_ext_q  <= 1'b0;
		end else begin
			cpu_vram_q <= cpu_rd && cpu_sel.vram && !ppu.needs_vram && !dma_vram;
			cpu_oam_q  <= cpu_rd && cpu_sel.oam && !ppu.needs_oam && !dma_active;
			cpu_ext_q  <= cpu_rd && cpu_ext && !dma_ext;
			cpu_dreg_q <= cpu_rd && cpu_sel.io && (cpu.adr[7:0] == DMA_REG_ADR[7:0]);
			ppu_vram_q <= ppu_vram_rd;
			ppu_oam_q  <= ppu_oam_rd;
			dma_vram_q <= dma_rd_g && dma_vram && !ppu.needs_vram;
			dma_ext_q  <= dma_rd_g && dma_ext;
		end
	end

	// Read data, a lost grant reads as open bus
	always_comb begin
		dma_rdata = OPEN_BUS;
		if (dma_vram_q)
			dma_rdata = vram_q;
		else if (dma_ext_q)
			dma_rdata = ext_rdata;

		cpu_rdata = OPEN_BUS;
		if (cpu_vram_q)
			cpu_rdata = vram_q;
		else if (cpu_oam_q)
			cpu_rdata = oam_q;
		else if (cpu_ext_q)
			cpu_rdata = ext_rdata;
		else if (cpu_dreg_q)
			cpu_rdata = dma_src_adr.paged.page;

		ppu_rdata = OPEN_BUS;
		if (ppu_vram_q)
			ppu_rdata = vram_q;
		else if (ppu_oam_q)
			ppu_rdata = oam_q;
	end

endmodule

// File: hdl/gb_system_bus.sv
module gb_system_bus (
	input  logic                 gbclk,
	input  logic                 rst_n,
	input  logic                 gb_on,
	input  gb_bus_pkg::cpu_req_t cpu,
	output logic [7:0]           cpu_rdata,
	input  gb_bus_pkg::ppu_req_t ppu,
	output logic [7:0]           ppu_rdata,
	output gb_bus_pkg::ext_bus_t ext,
	input  logic [7:0]           ext_rdata,
	output logic                 reset_done,
	output logic                 gb_reset,
	output logic                 dma_active
);
	import gb_bus_pkg::*;

	logic                 tick_done;
	logic                 tick_clear;
	bus_adr_u             cpu_adr;
	region_sel_t          cpu_sel;
	region_sel_t          dma_sel;
	logic                 cpu_dma_reg;
	logic                 dma_start;
	bus_adr_u             dma_src_adr;
	logic                 dma_rd;
	logic                 dma_oam_wr;
	logic [OAM_ADR_W-1:0] dma_oam_adr;

	assign cpu_adr.raw = cpu.adr;
	assign dma_start   = cpu_dma_reg && cpu.wr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reset sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	reset_sequencer u_seq (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.gb_on      (gb_on),
		.tick_done  (tick_done),
		.tick_clear (tick_clear),
		.reset_done (reset_done),
		.gb_reset   (gb_reset)
	);

	reset_tick_timer u_timer (
		.gbclk     (gbclk),
		.rst_n     (rst_n),
		.clear     (tick_clear),
		.tick_done (tick_done)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decode, DMA and memories
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	gb_memmap cpu_map (
		.adr     (cpu_adr),
		.sel     (cpu_sel),
		.dma_reg (cpu_dma_reg)
	);

	// DMA never addresses its own start register
	gb_memmap dma_map (
		.adr     (dma_src_adr),
		.sel     (dma_sel),
		.dma_reg ()
	);

	oam_dma u_dma (
		.gbclk     (gbclk),
		.rst_n     (rst_n),
		.bus_reset (gb_reset),
		.start     (dma_start),
		.page      (cpu.wdata),
		.src_adr   (dma_src_adr),
		.src_rd    (dma_rd),
		.oam_adr   (dma_oam_adr),
		.oam_wr    (dma_oam_wr),
		.active    (dma_active)
	);

	video_mem_arbiter u_arb (
		.gbclk       (gbclk),
		.rst_n       (rst_n),
		.bus_reset   (gb_reset),
		.cpu         (cpu),
		.cpu_sel     (cpu_sel),
		.ppu         (ppu),
		.dma_sel     (dma_sel),
		.dma_src_adr (dma_src_adr),
		.dma_rd      (dma_rd),
		.dma_oam_wr  (dma_oam_wr),
		.dma_active  (dma_active),
		.dma_oam_adr (dma_oam_adr),
		.ext_rdata   (ext_rdata),
		.ext         (ext),
		.cpu_rdata   (cpu_rdata),
		.ppu_rdata   (ppu_rdata)
	);

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
	output logic gbclk
);

	initial begin
		gbclk = 1'b0;
	end

	// Period of 10
	always begin
		#5;
		gbclk = ~gbclk;
	end

endmodule

// File: tests/gb_system_bus_sva.sv
module gb_system_bus_sva (
	input logic                 gbclk,
	input logic                 rst_n,
	input gb_bus_pkg::cpu_req_t cpu,
	input gb_bus_pkg::ext_bus_t ext,
	input logic                 reset_done,
	input logic                 gb_reset,
	input logic                 dma_active
);
	import gb_bus_pkg::*;

	int   fail_count = 0;
	logic cpu_go;

	// CPU owns the external bus
	assign cpu_go = (cpu.rd || cpu.wr) && !gb_reset && !dma_active;

	a_quiet_in_reset: assert property (@(posedge gbclk) !reset_done |-> !ext.rd && !ext.wr)
		else begin
			$error("External strobe while console is in reset");
			fail_count++;
		end

	a_rom_route: assert property (@(posedge gbclk) disable iff (!rst_n)
		cpu_go && (cpu.adr <= EXT_ROM_END) |->
		ext.cs_rom && !ext.cs_xram && !ext.cs_wram && (ext.adr == cpu.adr) &&
		(ext.rd == cpu.rd) && (ext.wr == cpu.wr))
		else begin
			$error("ROM access not routed to the external bus");
			fail_count++;
		end

	a_xram_route: assert property (@(posedge gbclk) disable iff (!rst_n)
		cpu_go && (cpu.adr >= XRAM_BASE) && (cpu.adr < WRAM_BASE) |->
		ext.cs_xram && !ext.cs_rom && !ext.cs_wram && (ext.adr == cpu.adr) &&
		(ext.rd == cpu.rd) && (ext.wr == cpu.wr))
		else begin
			$error("XRAM access not routed to the external bus");
			fail_count++;
		end

	a_wram_route: assert property (@(posedge gbclk) disable iff (!rst_n)
		cpu_go && (cpu.adr >= WRAM_BASE) && (cpu.adr <= WRAM_END) |->
		ext.cs_wram && !ext.cs_rom && !ext.cs_xram && (ext.adr == cpu.adr) &&
		(ext.rd == cpu.rd) && (ext.wr == cpu.wr))
		else begin
			$error("WRAM access not routed to the external bus");
			fail_count++;
		end

endmodule

bind gb_system_bus gb_system_bus_sva u_sva (
	.gbclk      (gbclk),
	.rst_n      (rst_n),
	.cpu        (cpu),
	.ext        (ext),
	.reset_done (reset_done),
	.gb_reset   (gb_reset),
	.dma_active (dma_active)
);

// File: tests/tb_gb_system_bus.sv
module tb_gb_system_bus;
	import gb_bus_pkg::*;

	logic       gbclk;
	logic       rst_n;
	logic       gb_on;
	cpu_req_t   cpu;
	logic [7:0] cpu_rdata;
	ppu_req_t   ppu;
	logic [7:0] ppu_rdata;
	ext_bus_t   ext;
	logic [7:0] ext_rdata = 8'h00;
	logic       reset_done;
	logic       gb_reset;
	logic       dma_active;

	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [7:0]  vram_shadow [int];
	logic [7:0]  oam_shadow [int];
	logic [15:0] vram_adrs [$];
	logic [15:0] oam_adrs [$];
	logic [15:0] ext_wr_adr [$];
	logic [7:0]  ext_wr_data [$];

	tb_clock_gen u_clk (.gbclk(gbclk));

	gb_system_bus UUT (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.gb_on      (gb_on),
		.cpu        (cpu),
		.cpu_rdata  (cpu_rdata),
		.ppu        (ppu),
		.ppu_rdata  (ppu_rdata),
		.ext        (ext),
		.ext_rdata  (ext_rdata),
		.reset_done (reset_done),
		.gb_reset   (gb_reset),
		.dma_active (dma_active)
	);

	// External memory model, one cycle read latency
	always @(posedge gbclk) begin
		if (ext.rd)
			ext_rdata <= ext.adr[7:0] ^ 8'h5a;
		if (ext.wr) begin
			ext_wr_adr.push_back(ext.adr);
			ext_wr_data.push_back(ext.wdata);
		end
	end

	task automatic tick();
		@(posedge gbclk);
		#1;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Verification failed");
		$finish;
	endtask

	task automatic check_value(input string test, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("Error %s: expected %0h, actual %0h", test, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// Edges until reset_done reaches the level
	task automatic count_edges_to_done(input logic level, output int n);
		n = 0;
		do begin
			tick();
			n++;
		end while (reset_done !== level && n < 200);
		if (reset_done !== level)
			abort_on_timeout("reset_done");
	endtask

	task automatic cpu_write(input logic [15:0] adr, input logic [7:0] data);
		cpu.adr   = adr;
		cpu.wdata = data;
		cpu.wr    = 1'b1;
		tick();
		cpu.wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] adr, output logic [7:0] data);
		cpu.adr = adr;
		cpu.rd  = 1'b1;
		tick();
		cpu.rd = 1'b0;
		data   = cpu_rdata;
	endtask

	task automatic run_reset_test();
		int         n;
		logic [7:0] data;
		count_edges_to_done(1'b1, n);
		check_value("reset_power_on", 48, n);
		check_value("gb_reset_power_on", 0, gb_reset);
		// reset_done follows the switch one edge later
		gb_on = 1'b0;
		#1;
		check_value("gb_reset_switch_off", 1, gb_reset);
		tick();
		check_value("reset_switch_off", 0, reset_done);
		// Strobes while the console is held in reset
		cpu_read(16'h0150, data);
		check_value("reset_rom_read", OPEN_BUS, data);
		cpu_write(WRAM_BASE, 8'h3c);
		check_value("reset_wram_write", 0, ext_wr_adr.size());
		cpu_write(DMA_REG_ADR, 8'h00);
		check_value("reset_dma_start", 0, dma_active);
		tick();
		gb_on = 1'b1;
		tick();
		count_edges_to_done(1'b1, n);
		check_value("reset_switch_on", 32, n);
		check_value("gb_reset_switch_on", 0, gb_reset);
		finish_test("reset_sequence");
	endtask

	task automatic run_storage_test();
		logic [15:0] adr;
		logic [7:0]  data;
		logic [7:0]  offset;
		for (int i = 0; i < 8; i++) begin
			adr  = VRAM_BASE + 16'($urandom % 8192);
			data = 8'($urandom);
			cpu_write(adr, data);
			vram_shadow[adr] = data;
			vram_adrs.push_back(adr);
			adr  = OAM_BASE + 16'($urandom % OAM_BYTES);
			data = 8'($urandom);
			cpu_write(adr, data);
			oam_shadow[adr] = data;
			oam_adrs.push_back(adr);
		end
		foreach (vram_adrs[i]) begin
			cpu_read(vram_adrs[i], data);
			check_value("vram_readback", vram_shadow[vram_adrs[i]], data);
		end
		foreach (oam_adrs[i]) begin
			cpu_read(oam_adrs[i], data);
			check_value("oam_readback", oam_shadow[oam_adrs[i]], data);
		end
		offset = 8'($urandom);
		if (offset == DMA_REG_ADR[7:0])
			offset = offset + 8'd1;
		cpu_read({IO_BASE[15:8], offset}, data);
		check_value("io_open_bus", OPEN_BUS, data);
		finish_test("vram_oam_storage");
	endtask

	task automatic run_ppu_test();
		logic [15:0] va;
		logic [15:0] oa;
		logic [7:0]  data;
		va = vram_adrs[0];
		oa = oam_adrs[0];
		// PPU and CPU read VRAM in the same cycle
		ppu.adr        = va;
		ppu.needs_vram = 1'b1;
		ppu.rd         = 1'b1;
		cpu_read(va, data);
		ppu.rd = 1'b0;
		check_value("ppu_vram_read", vram_shadow[va], ppu_rdata);
		check_value("cpu_vram_blocked", OPEN_BUS, data);
		cpu_write(va, ~vram_shadow[va]);
		ppu.needs_vram = 1'b0;
		cpu_read(va, data);
		check_value("vram_write_dropped", vram_shadow[va], data);

		ppu.adr       = oa;
		ppu.needs_oam = 1'b1;
		ppu.rd        = 1'b1;
		cpu_read(oa, data);
		ppu.rd = 1'b0;
		check_value("ppu_oam_read", oam_shadow[oa], ppu_rdata);
		check_value("cpu_oam_blocked", OPEN_BUS, data);
		cpu_write(oa, ~oam_shadow[oa]);
		ppu.needs_oam = 1'b0;
		cpu_read(oa, data);
		check_value("oam_write_dropped", oam_shadow[oa], data);
		finish_test("ppu_priority");
	endtask

	task automatic run_ext_test();
		logic [15:0] adr;
		logic [7:0]  data;
		logic [7:0]  wdata;
		adr = 16'($urandom % 32768);
		cpu_read(adr, data);
		check_value("rom_read", adr[7:0] ^ 8'h5a, data);
		adr = XRAM_BASE + 16'($urandom % 8192);
		cpu_read(adr, data);
		check_value("xram_read", adr[7:0] ^ 8'h5a, data);
		adr = WRAM_BASE + 16'($urandom % 8192);
		cpu_read(adr, data);
		check_value("wram_read", adr[7:0] ^ 8'h5a, data);
		wdata = 8'($urandom);
		cpu_write(adr, wdata);
		if (ext_wr_adr.size() == 0) begin
			$display("WRAM write never reached the external bus");
			test_errors++;
		end else begin
			check_value("wram_write_adr", adr, ext_wr_adr[$]);
			check_value("wram_write_data", wdata, ext_wr_data[$]);
		end
		finish_test("external_routing");
	endtask

	task automatic run_dma_test();
		logic [7:0] page;
		logic [7:0] data;
		int         n;
		page = 8'($urandom % 128);
		cpu_write(DMA_REG_ADR, page);
		check_value("dma_start", 1, dma_active);
		n = 1;
		while (dma_active === 1'b1 && n < 400) begin
			cpu.adr = OAM_BASE + 16'(n % OAM_BYTES);
			cpu.rd  = (n == 40);
			tick();
			if (cpu.rd)
				check_value("oam_busy_read", OPEN_BUS, cpu_rdata);
			cpu.rd = 1'b0;
			if (dma_active)
				n++;
		end
		if (n >= 400)
			abort_on_timeout("end of OAM DMA");
		else begin
			check_value("dma_length", 161, n);
			for (int i = 0; i < OAM_BYTES; i++) begin
				cpu_read(OAM_BASE + 16'(i), data);
				check_value("dma_oam_byte", 8'(i) ^ 8'h5a, data);
				oam_shadow[OAM_BASE + i] = 8'(i) ^ 8'h5a;
			end
			finish_test("oam_dma");
		end
	endtask

	initial begin
		void'($urandom(88363));
		rst_n = 1'b0;
		gb_on = 1'b1;
		cpu   = '0;
		ppu   = '0;
		repeat (8) @(posedge gbclk);
		#1;
		rst_n = 1'b1;

		run_reset_test();
		run_storage_test();
		run_ppu_test();
		run_ext_test();
		run_dma_test();

		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			tests_passed, tests_failed, UUT.u_sva.fail_count);
		if (tests_failed == 0 && UUT.u_sva.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: gb_system_bus.f
hdl/gb_bus_pkg.sv
hdl/gb_reset_pkg.sv
hdl/reset_tick_timer.sv
hdl/reset_sequencer.sv
hdl/gb_memmap.sv
hdl/oam_dma.sv
hdl/video_mem_arbiter.sv
hdl/gb_system_bus.sv
tests/tb_clock_gen.sv
tests/gb_system_bus_sva.sv
tests/tb_gb_system_bus.sv

// File: Makefile
SRCS := $(shell grep -v '^+' gb_system_bus.f)
SIM  := obj_dir/Vtb_gb_system_bus

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

$(SIM): gb_system_bus.f $(SRCS)
	verilator --binary --timing --assert -f gb_system_bus.f \
		--top-module tb_gb_system_bus -o Vtb_gb_system_bus

clean:
	rm -rf obj_dir
